// File: verilog/dma_pkg.sv
package dma_pkg;

	localparam int WB_DW      = 32;
	localparam int WB_AW      = 32;
	localparam int WORD_BYTES = 4; // bytes per bus word
	localparam int ROWS_W     = 8;
	localparam int WORDS_W    = 8;

	// transfer direction
	typedef enum logic {
		OP_LOAD  = 1'b0, // memory to buffer
		OP_STORE = 1'b1  // buffer to memory
	} dma_op_e;

	typedef enum logic [3:0] {
		ST_IDLE,
		ST_ROW_SETUP,
		ST_FETCH_FIRST,
		ST_FETCH,
		ST_LAST_SHIFT,
		ST_BUS_WRITE,
		ST_BUS_READ,
		ST_UNPACK,
		ST_NEXT_WORD,
		ST_FINISH
	} dma_state_e;

endpackage

// File: verilog/word_shifter.sv
module word_shifter
	import dma_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic             shift_in,
	input  logic             shift_out,
	input  logic             load_word,
	input  logic [7:0]       byte_in,
	input  logic [WB_DW-1:0] word_in,
	output logic [WB_DW-1:0] word_out,
	output logic [7:0]       top_byte
);

	logic [WB_DW-1:0] sreg;

	// pack on store, unpack on load; never both in one cycle
	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n)
			sreg <= '0;
		else if (load_word)
			sreg <= word_in;
		else if (shift_in)
			sreg <= {sreg[WB_DW-9:0], byte_in}; // first byte ends up in 31:24
		else if (shift_out)
			sreg <= {sreg[WB_DW-9:0], 8'h00};
	end

	assign word_out = sreg;
	assign top_byte = sreg[WB_DW-1 -: 8];

endmodule

// File: verilog/tile_buffer.sv
module tile_buffer #(
	parameter int BUF_DEPTH = 1024
) (
	input  logic                         clk,
	input  logic                         host_we,
	input  logic [$clog2(BUF_DEPTH)-1:0] host_addr,
	input  logic [7:0]                   host_wdata,
	input  logic                         dma_we,
	input  logic [$clog2(BUF_DEPTH)-1:0] dma_addr,
	input  logic [7:0]                   dma_wdata,
	output logic [7:0]                   host_rdata,
	output logic [7:0]                   dma_rdata
);

	logic [7:0] mem [BUF_DEPTH];

	// both ports write and read every cycle
	always_ff @(posedge clk) begin
		if (host_we)
			mem[host_addr] <= host_wdata;
		if (dma_we)
			mem[dma_addr] <= dma_wdata;
		host_rdata <= mem[host_addr];
		dma_rdata  <= mem[dma_addr]; // old data on a same-port write
	end

endmodule

// File: verilog/dma_addr_gen.sv
module dma_addr_gen
	import dma_pkg::*;
#(
	parameter int BUF_DEPTH = 1024
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         cnt_load,
	input  logic                         byte_step,
	input  logic                         word_step,
	input  logic                         row_step,
	input  logic [WB_AW-1:0]             mem_base,
	input  logic [ROWS_W-1:0]            rows,
	input  logic [WORDS_W-1:0]           row_words,
	input  logic [WB_AW-1:0]             mem_stride,
	output logic [$clog2(BUF_DEPTH)-1:0] dma_buf_addr,
	output logic [WB_AW-1:0]             wb_adr,
	output logic                         last_byte,
	output logic                         last_word,
	output logic                         last_row
);

	logic [$clog2(WORD_BYTES)-1:0] byte_cnt;
	logic [WORDS_W-1:0]            word_cnt;
	logic [ROWS_W-1:0]             row_cnt;
	logic [ROWS_W-1:0]             rows_q;
	logic [WORDS_W-1:0]            row_words_q;
	logic [WB_AW-1:0]              stride_q;
	logic [WB_AW-1:0]              row_base;

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			byte_cnt     <= '0;
			word_cnt     <= '0;
			row_cnt      <= '0;
			rows_q       <= '0;
			row_words_q  <= '0;
			stride_q     <= '0;
			row_base     <= '0;
			wb_adr       <= '0;
			dma_buf_addr <= '0;
		end else if (cnt_load) begin
			byte_cnt     <= '0;
			word_cnt     <= '0;
			row_cnt      <= '0;
			rows_q       <= rows;
			row_words_q  <= row_words;
			stride_q     <= mem_stride;
			row_base     <= mem_base;
			wb_adr       <= mem_base;
			dma_buf_addr <= '0; // tile sits at byte 0
		end else begin
			if (byte_step) begin
				byte_cnt     <= byte_cnt + 1'b1;
				dma_buf_addr <= dma_buf_addr + 1'b1;
			end
			if (row_step) begin
				word_cnt <= '0;
				row_cnt  <= row_cnt + 1'b1;
				row_base <= row_base + stride_q;
				wb_adr   <= row_base + stride_q;
			end else if (word_step) begin
				word_cnt <= word_cnt + 1'b1;
				wb_adr   <= wb_adr + WB_AW'(WORD_BYTES);
			end
		end
	end

	assign last_byte = &byte_cnt; // word size is a power of two
	assign last_word = (word_cnt == row_words_q - 1'b1);
	assign last_row  = (row_cnt == rows_q - 1'b1);

endmodule

// File: verilog/dma_ctrl_fsm.sv
module dma_ctrl_fsm
	import dma_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  logic    start,
	input  dma_op_e op,
	input  logic    last_byte,
	input  logic    last_word,
	input  logic    last_row,
	input  logic    wb_ack,
	output logic    busy,
	output logic    done,
	output logic    cnt_load,
	output logic    byte_step,
	output logic    word_step,
	output logic    row_step,
	output logic    shift_in,
	output logic    shift_out,
	output logic    load_word,
	output logic    dma_buf_we,
	output logic    wb_cyc,
	output logic    wb_stb,
	output logic    wb_we
);

	dma_state_e state;
	dma_state_e next;
	dma_op_e    op_q; // direction of the running command
	logic       word_done;

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			op_q  <= OP_LOAD;
			done  <= 1'b0;
		end else begin
			state <= next;
			done  <= (state == ST_FINISH); // lines up with busy falling
			if (cnt_load)
				op_q <= op;
		end
	end

	// store ends with the bus ack, load with the fourth byte write
	assign word_done = (state == ST_BUS_WRITE && wb_ack) ||
		(state == ST_UNPACK && last_byte);

	always_comb begin
		next = state;
		case (state)
			ST_IDLE: begin
				if (start)
					next = ST_ROW_SETUP;
			end
			ST_ROW_SETUP: begin
				if (op_q == OP_STORE)
					next = ST_FETCH_FIRST;
				else
					next = ST_BUS_READ;
			end
			ST_FETCH_FIRST, ST_NEXT_WORD: begin
				next = ST_FETCH;
			end
			ST_FETCH: begin
				if (last_byte)
					next = ST_LAST_SHIFT;
			end
			ST_LAST_SHIFT: begin
				next = ST_BUS_WRITE;
			end
			ST_BUS_READ: begin
				if (wb_ack)
					next = ST_UNPACK;
			end
			ST_BUS_WRITE, ST_UNPACK: begin
				if (word_done) begin
					if (last_word && last_row)
						next = ST_FINISH;
					else if (last_word)
						next = ST_ROW_SETUP;
					else if (op_q == OP_STORE)
						next = ST_NEXT_WORD; // first read of the next word
					else
						next = ST_BUS_READ;
				end
			end
			ST_FINISH: begin
				next = ST_IDLE;
			end
			default: begin
				next = ST_IDLE;
			end
		endcase
	end

	assign busy     = (state != ST_IDLE);
	assign cnt_load = (state == ST_IDLE) && start;

	// store word step waits for the ack, so wb_adr holds during the write
	assign word_step = (state == ST_NEXT_WORD) ||
		(state == ST_UNPACK && last_byte && !last_word);
	assign row_step  = word_done && last_word && !last_row;

	assign byte_step = (state == ST_FETCH_FIRST) || (state == ST_NEXT_WORD) ||
		(state == ST_FETCH) || (state == ST_UNPACK);

	assign shift_in   = (state == ST_FETCH) || (state == ST_LAST_SHIFT); // one cycle read latency
	assign shift_out  = (state == ST_UNPACK);
	assign load_word  = (state == ST_BUS_READ) && wb_ack;
	assign dma_buf_we = (state == ST_UNPACK);

	assign wb_cyc = (state == ST_BUS_WRITE) || (state == ST_BUS_READ);
	assign wb_stb = wb_cyc;
	assign wb_we  = (state == ST_BUS_WRITE);

endmodule

// File: verilog/tile_dma_top.sv
module tile_dma_top
	import dma_pkg::*;
#(
	parameter int BUF_DEPTH = 1024
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         start,
	input  dma_op_e                      op,
	input  logic [WB_AW-1:0]             mem_base,
	input  logic [ROWS_W-1:0]            rows,
	input  logic [WORDS_W-1:0]           row_words,
	input  logic [WB_AW-1:0]             mem_stride,
	output logic                         busy,
	output logic                         done,
	input  logic                         buf_we,
	input  logic [$clog2(BUF_DEPTH)-1:0] buf_addr,
	input  logic [7:0]                   buf_wdata,
	output logic [7:0]                   buf_rdata,
	output logic                         wb_cyc,
	output logic                         wb_stb,
	output logic                         wb_we,
	output logic [WB_AW-1:0]             wb_adr,
	output logic [WB_DW-1:0]             wb_dat_o,
	input  logic [WB_DW-1:0]             wb_dat_i,
	input  logic                         wb_ack
);

	logic                         cnt_load;
	logic                         byte_step;
	logic                         word_step;
	logic                         row_step;
	logic                         last_byte;
	logic                         last_word;
	logic                         last_row;
	logic                         shift_in;
	logic                         shift_out;
	logic                         load_word;
	logic                         dma_buf_we;
	logic [$clog2(BUF_DEPTH)-1:0] dma_buf_addr;
	logic [7:0]                   dma_rdata;
	logic [7:0]                   dma_wdata;

	dma_ctrl_fsm dma_ctrl_fsm_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.op         (op),
		.last_byte  (last_byte),
		.last_word  (last_word),
		.last_row   (last_row),
		.wb_ack     (wb_ack),
		.busy       (busy),
		.done       (done),
		.cnt_load   (cnt_load),
		.byte_step  (byte_step),
		.word_step  (word_step),
		.row_step   (row_step),
		.shift_in   (shift_in),
		.shift_out  (shift_out),
		.load_word  (load_word),
		.dma_buf_we (dma_buf_we),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we)
	);

	dma_addr_gen #(
		.BUF_DEPTH (BUF_DEPTH)
	) dma_addr_gen_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.cnt_load     (cnt_load),
		.byte_step    (byte_step),
		.word_step    (word_step),
		.row_step     (row_step),
		.mem_base     (mem_base),
		.rows         (rows),
		.row_words    (row_words),
		.mem_stride   (mem_stride),
		.dma_buf_addr (dma_buf_addr),
		.wb_adr       (wb_adr),
		.last_byte    (last_byte),
		.last_word    (last_word),
		.last_row     (last_row)
	);

	word_shifter word_shifter_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.shift_in  (shift_in),
		.shift_out (shift_out),
		.load_word (load_word),
		.byte_in   (dma_rdata),
		.word_in   (wb_dat_i),
		.word_out  (wb_dat_o),
		.top_byte  (dma_wdata)
	);

	tile_buffer #(
		.BUF_DEPTH (BUF_DEPTH)
	) tile_buffer_i (
		.clk        (clk),
		.host_we    (buf_we),
		.host_addr  (buf_addr),
		.host_wdata (buf_wdata),
		.dma_we     (dma_buf_we),
		.dma_addr   (dma_buf_addr),
		.dma_wdata  (dma_wdata),
		.host_rdata (buf_rdata),
		.dma_rdata  (dma_rdata)
	);

endmodule

// File: bench/wb_mem_model.sv
module wb_mem_model
	import dma_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic             cyc,
	input  logic             stb,
	input  logic             we,
	input  logic [WB_AW-1:0] adr,
	input  logic [WB_DW-1:0] dat_i,
	output logic [WB_DW-1:0] dat_o,
	output logic             ack
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [WB_DW-1:0] mem [4096];
	logic [31:0]      rng;
	logic [1:0]       wait_cnt; // wait states spent in the current access

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// low rng bits give 0 to 3 wait states
	assign ack   = cyc && stb && (wait_cnt == rng[1:0]);
	assign dat_o = mem[adr[13:2]];

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rng      <= 32'd39324;
			wait_cnt <= '0;
		end else if (ack) begin
			rng      <= xorshift(rng); // draw for the next access
			wait_cnt <= '0;
		end else if (cyc && stb) begin
			wait_cnt <= wait_cnt + 1'b1;
		end
	end

	always @(posedge clk) begin
		if (ack && we)
			mem[adr[13:2]] <= dat_i;
	end

endmodule

// File: bench/tb_tile_dma.sv
module tb_tile_dma
	import dma_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int TOTAL_WORDS = 4 + 4 + 6 + 12 + 12;
	localparam int MAX_CYCLES  = TOTAL_WORDS * 12 + 200;

	logic               clk = 1'b0;
	logic               rst_n;
	logic               start;
	dma_op_e            op;
	logic [WB_AW-1:0]   mem_base;
	logic [ROWS_W-1:0]  rows;
	logic [WORDS_W-1:0] row_words;
	logic [WB_AW-1:0]   mem_stride;
	logic               busy;
	logic               done;
	logic               buf_we;
	logic [9:0]         buf_addr;
	logic [7:0]         buf_wdata;
	logic [7:0]         buf_rdata;
	logic               wb_cyc;
	logic               wb_stb;
	logic               wb_we;
	logic [WB_AW-1:0]   wb_adr;
	logic [WB_DW-1:0]   wb_dat_o;
	logic [WB_DW-1:0]   wb_dat_i;
	logic               wb_ack;
	logic [7:0]         tile [64]; // expected buffer contents
	logic [31:0]        rng = 32'd39324;
	int                 errors = 0;
	int                 pass_cnt = 0;
	int                 fail_cnt = 0;
	int                 n_done = 0;
	int                 n_writes = 0;
	int                 n_reads = 0;
	int                 cycles = 0;

	always #50 clk = ~clk;

	tile_dma_top #(.BUF_DEPTH(1024)) tile_dma_top_i (.*);

	wb_mem_model mem_i (
		.clk   (clk),
		.rst_n (rst_n),
		.cyc   (wb_cyc),
		.stb   (wb_stb),
		.we    (wb_we),
		.adr   (wb_adr),
		.dat_i (wb_dat_o),
		.dat_o (wb_dat_i),
		.ack   (wb_ack)
	);

	always @(negedge clk) begin
		if (done)
			n_done++;
		if (wb_cyc && wb_stb && wb_ack) begin
			if (wb_we)
				n_writes++;
			else
				n_reads++;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] fill_word(input logic [11:0] j);
		return {20'hc0de0, j};
	endfunction

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("FAIL %s expected %h got %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_word(input string name, input logic [WB_DW-1:0] exp,
		input logic [WB_DW-1:0] act);
		if (act !== exp) begin
			$display("FAIL %s expected %h got %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_op_done(input dma_op_e o, input logic done_v, input logic busy_v);
		if (done_v !== 1'b1 || busy_v !== 1'b0) begin
			$display("FAIL done/busy after %s expected 1/0 got %h/%h", o.name(), done_v, busy_v);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("FAIL %s expected %h got %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("FAIL %s expected %h got %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic send_cmd(input dma_op_e o, input logic [WB_AW-1:0] base,
		input logic [ROWS_W-1:0] r, input logic [WORDS_W-1:0] w, input logic [WB_AW-1:0] stride);
		@(posedge clk);
		#5;
		start = 1'b1;
		op = o;
		mem_base = base;
		rows = r;
		row_words = w;
		mem_stride = stride;
		@(posedge clk);
		#5;
		start = 1'b0;
	endtask

	task automatic wait_done(input dma_op_e o);
		int d0;
		d0 = n_done;
		do
			@(negedge clk);
		while (busy && !done);
		check_op_done(o, done, busy);
		repeat (3) @(negedge clk);
		check_count("done pulses", d0 + 1, n_done);
	endtask

	task automatic write_bytes(input int n, input logic clear);
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			#5;
			buf_we = 1'b1;
			buf_addr = 10'(i);
			buf_wdata = clear ? 8'h00 : tile[i];
		end
		@(posedge clk);
		#5;
		buf_we = 1'b0;
	endtask

	task automatic read_bytes(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			#5;
			buf_addr = 10'(i);
			@(negedge clk);
			@(negedge clk); // registered read
			check_byte($sformatf("buf_rdata[%0d]", i), tile[i], buf_rdata);
		end
	endtask

	task automatic check_mem_tile(input logic [31:0] base, input int r, input int w,
		input logic [31:0] stride);
		logic [31:0] a;
		int          i;
		for (int ri = 0; ri < r; ri++)
			for (int k = 0; k < w; k++) begin
				a = base + ri * stride + 4 * k;
				i = (ri * w + k) * 4;
				check_word($sformatf("mem[%h]", a), {tile[i], tile[i+1], tile[i+2], tile[i+3]},
					mem_i.mem[a[13:2]]);
			end
	endtask

	task automatic finish_test(input string name, input int e0);
		if (errors == e0) begin
			pass_cnt++;
			$display("test %s: ok", name);
		end else begin
			fail_cnt++;
			$display("test %s: %0d errors", name, errors - e0);
		end
	endtask

	task automatic test_reset_restart();
		int e0;
		e0 = errors;
		@(negedge clk);
		check_flag("busy", 1'b0, busy);
		check_flag("done", 1'b0, done);
		check_flag("wb_cyc", 1'b0, wb_cyc);
		check_flag("wb_stb", 1'b0, wb_stb);
		check_flag("wb_we", 1'b0, wb_we);
		send_cmd(OP_LOAD, 32'h800, 1, 4, 32'h10);
		repeat (3) @(negedge clk);
		check_flag("busy", 1'b1, busy);
		send_cmd(OP_STORE, 32'h900, 2, 2, 32'h10); // must be ignored
		wait_done(OP_LOAD);
		repeat (20) @(negedge clk);
		check_count("bus writes", 0, n_writes);
		check_count("bus reads", 4, n_reads);
		check_count("done total", 1, n_done);
		finish_test("reset and start while busy", e0);
	endtask

	task automatic test_store_row();
		int e0;
		e0 = errors;
		for (int i = 0; i < 16; i++)
			tile[i] = 8'(8'h11 * i + 8'h05);
		write_bytes(16, 1'b0);
		send_cmd(OP_STORE, 32'h100, 1, 4, 32'h10);
		wait_done(OP_STORE);
		check_mem_tile(32'h100, 1, 4, 32'h10);
		finish_test("single-row store", e0);
	endtask

	task automatic test_store_stride();
		int          e0;
		logic [31:0] a;
		e0 = errors;
		for (int i = 0; i < 24; i++)
			tile[i] = 8'(8'hf0 - 3 * i);
		write_bytes(24, 1'b0);
		send_cmd(OP_STORE, 32'h200, 3, 2, 32'h40);
		wait_done(OP_STORE);
		check_mem_tile(32'h200, 3, 2, 32'h40);
		for (int ri = 0; ri < 3; ri++)
			for (int off = 8; off < 32'h40; off += 4) begin
				a = 32'h200 + ri * 32'h40 + off;
				check_word($sformatf("gap mem[%h]", a), fill_word(a[13:2]), mem_i.mem[a[13:2]]);
			end
		finish_test("multi-row store with stride", e0);
	endtask

	task automatic test_load_rows();
		int          e0;
		logic [31:0] a;
		e0 = errors;
		for (int ri = 0; ri < 4; ri++)
			for (int k = 0; k < 3; k++) begin
				a = 32'h400 + ri * 32'h20 + 4 * k;
				rng = xorshift(rng);
				mem_i.mem[a[13:2]] = rng;
				for (int b = 0; b < 4; b++)
					tile[(ri * 3 + k) * 4 + b] = rng[31 - 8 * b -: 8]; // msb is lowest byte
			end
		send_cmd(OP_LOAD, 32'h400, 4, 3, 32'h20);
		wait_done(OP_LOAD);
		read_bytes(48);
		finish_test("multi-row load", e0);
	endtask

	task automatic test_round_trip();
		int e0;
		e0 = errors;
		for (int i = 0; i < 24; i++) begin
			rng = xorshift(rng);
			tile[i] = rng[7:0];
		end
		write_bytes(24, 1'b0);
		send_cmd(OP_STORE, 32'h600, 2, 3, 32'h10);
		wait_done(OP_STORE);
		check_mem_tile(32'h600, 2, 3, 32'h10);
		write_bytes(24, 1'b1);
		send_cmd(OP_LOAD, 32'h600, 2, 3, 32'h10);
		wait_done(OP_LOAD);
		read_bytes(24);
		finish_test("store and load round trip", e0);
	endtask

	initial begin
		while (cycles < MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: DUT did not finish");
		$display("Regression failed");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		start = 1'b0;
		op = OP_LOAD;
		mem_base = '0;
		rows = '0;
		row_words = '0;
		mem_stride = '0;
		buf_we = 1'b0;
		buf_addr = '0;
		buf_wdata = '0;
		for (int j = 0; j < 4096; j++)
			mem_i.mem[j] = fill_word(12'(j));
		repeat (2) @(posedge clk);
		#5;
		rst_n = 1'b1;
		test_reset_restart();
		test_store_row();
		test_store_stride();
		test_load_rows();
		test_round_trip();
		$display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// File: filelist.f
verilog/dma_pkg.sv
verilog/word_shifter.sv
verilog/tile_buffer.sv
verilog/dma_addr_gen.sv
verilog/dma_ctrl_fsm.sv
verilog/tile_dma_top.sv
bench/wb_mem_model.sv
bench/tb_tile_dma.sv

// File: Bender.yml
package:
  name: tile_dma

sources:
  - verilog/dma_pkg.sv
  - verilog/word_shifter.sv
  - verilog/tile_buffer.sv
  - verilog/dma_addr_gen.sv
  - verilog/dma_ctrl_fsm.sv
  - verilog/tile_dma_top.sv
  - target: simulation
    files:
      - bench/wb_mem_model.sv
      - bench/tb_tile_dma.sv
